/* hdl/trap_pkg.sv */
`default_nettype none

package trap_pkg;

    // Plain vector types for the widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0]  csr_w_type_t;

    // How a CSR write combines the operand with the old value
    localparam csr_w_type_t CSR_W_COPY  = 2'd0;
    localparam csr_w_type_t CSR_W_SET   = 2'd1;
    localparam csr_w_type_t CSR_W_CLEAR = 2'd2;

    // Machine-mode CSR addresses
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;

    // Exception codes for the two machine interrupts
    localparam word_t INT_CODE_TIMER    = 32'd7;
    localparam word_t INT_CODE_EXTERNAL = 32'd11;

    // Mode field in the low two bits of mtvec
    localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'd0;
    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;

    // Bit positions inside mstatus
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Bit positions shared by mie and mip
    localparam int INT_TIMER_BIT    = 7;
    localparam int INT_EXTERNAL_BIT = 11;

endpackage

`default_nettype wire

/* hdl/csr_file.sv */
`default_nettype none

module csr_file #(
    parameter trap_pkg::word_t MTVEC_RESET_BASE = '0
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_int_timer,
    input  logic                  i_int_ext,
    input  logic                  i_csr_w_en,
    input  trap_pkg::csr_addr_t   i_csr_addr,
    input  trap_pkg::csr_w_type_t i_csr_w_type,
    input  trap_pkg::word_t       i_csr_operand,
    input  logic                  i_restore_int_en,
    input  logic                  i_trap_dispatch,
    input  trap_pkg::word_t       i_trap_cause,
    input  trap_pkg::word_t       i_fetch_pc,
    output trap_pkg::word_t       o_csr_r_data,
    output trap_pkg::word_t       o_mepc,
    output trap_pkg::word_t       o_mtvec,
    output logic                  o_mstatus_mie,
    output logic                  o_timer_pending,
    output logic                  o_ext_pending
);
    import trap_pkg::*;

    // Bit 1 of mtvec is the upper mode bit and stays zero
    localparam word_t MTVEC_W_MASK = ~word_t'(32'h2);

    word_t r_mstatus;
    word_t r_mie;
    word_t r_mtvec;
    word_t r_mscratch;
    word_t r_mepc;
    word_t r_mcause;
    word_t r_mtval;
    word_t r_mip;

    word_t w_csr_r_data;
    word_t w_csr_w_data;
    word_t w_mip_sampled;
    word_t r_csr_r_data;

    // The read mux follows the live address, and a write uses the same
    // address, so SET and CLEAR see the old value of the target register
    always_comb begin
        case (i_csr_addr)
            CSR_ADDR_MSTATUS:  w_csr_r_data = r_mstatus;
            CSR_ADDR_MIE:      w_csr_r_data = r_mie;
            CSR_ADDR_MTVEC:    w_csr_r_data = r_mtvec;
            CSR_ADDR_MSCRATCH: w_csr_r_data = r_mscratch;
            CSR_ADDR_MEPC:     w_csr_r_data = r_mepc;
            CSR_ADDR_MCAUSE:   w_csr_r_data = r_mcause;
            CSR_ADDR_MTVAL:    w_csr_r_data = r_mtval;
            CSR_ADDR_MIP:      w_csr_r_data = r_mip;
            default:           w_csr_r_data = '0;
        endcase
    end

    // Modified write value
    always_comb begin
        case (i_csr_w_type)
            CSR_W_SET:   w_csr_w_data = w_csr_r_data | i_csr_operand;
            CSR_W_CLEAR: w_csr_w_data = w_csr_r_data & ~i_csr_operand;
            default:     w_csr_w_data = i_csr_operand;
        endcase
    end

    // Only the timer and external pending bits exist in mip
    always_comb begin
        w_mip_sampled                   = '0;
        w_mip_sampled[INT_TIMER_BIT]    = i_int_timer;
        w_mip_sampled[INT_EXTERNAL_BIT] = i_int_ext;
    end

    // Read data is registered and shows up one cycle after the address
    always_ff @(posedge i_clk) begin
        r_csr_r_data <= w_csr_r_data;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_mstatus  <= '0;
            r_mie      <= '0;
            r_mtvec    <= {MTVEC_RESET_BASE[31:2], MTVEC_MODE_DIRECT};
            r_mscratch <= '0;
            r_mepc     <= '0;
            r_mcause   <= '0;
            r_mtval    <= '0;
            r_mip      <= '0;
        end else begin
            r_mip <= w_mip_sampled;

            // Trap entry wins over any software access in the same cycle
            if (i_trap_dispatch) begin
                r_mepc                      <= i_fetch_pc;
                r_mcause                    <= i_trap_cause;
                r_mtval                     <= '0;
                r_mstatus[MSTATUS_MPIE_BIT] <= r_mstatus[MSTATUS_MIE_BIT];
                r_mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (i_csr_w_en) begin
                // mip has no entry here since it is read-only
                case (i_csr_addr)
                    CSR_ADDR_MSTATUS:  r_mstatus  <= w_csr_w_data;
                    CSR_ADDR_MIE:      r_mie      <= w_csr_w_data;
                    CSR_ADDR_MTVEC:    r_mtvec    <= w_csr_w_data & MTVEC_W_MASK;
                    CSR_ADDR_MSCRATCH: r_mscratch <= w_csr_w_data;
                    CSR_ADDR_MEPC:     r_mepc     <= w_csr_w_data;
                    CSR_ADDR_MCAUSE:   r_mcause   <= w_csr_w_data;
                    CSR_ADDR_MTVAL:    r_mtval    <= w_csr_w_data;
                    default: begin
                        // Unknown addresses take no write
                    end
                endcase
            end else if (i_restore_int_en) begin
                // Return from trap brings back the enable saved at trap entry
                r_mstatus[MSTATUS_MIE_BIT]  <= r_mstatus[MSTATUS_MPIE_BIT];
                r_mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
            end
        end
    end

    always_comb begin
        o_csr_r_data  = r_csr_r_data;
        o_mepc        = r_mepc;
        o_mtvec       = r_mtvec;
        o_mstatus_mie = r_mstatus[MSTATUS_MIE_BIT];
    end

    // Pending bits leave already qualified by their individual enables,
    // the global enable is applied in the trap controller
    always_comb begin
        o_timer_pending = r_mip[INT_TIMER_BIT] & r_mie[INT_TIMER_BIT];
        o_ext_pending   = r_mip[INT_EXTERNAL_BIT] & r_mie[INT_EXTERNAL_BIT];
    end

endmodule

`default_nettype wire

/* hdl/trap_controller.sv */
`default_nettype none

module trap_controller (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_mstatus_mie,
    input  logic            i_timer_pending,
    input  logic            i_ext_pending,
    input  trap_pkg::word_t i_mtvec,
    input  logic            i_pipeline_empty,
    input  logic            i_branch_redirect_valid,
    input  trap_pkg::word_t i_branch_target,
    output logic            o_trap_dispatch,
    output trap_pkg::word_t o_trap_cause,
    output logic            o_redirect_valid,
    output trap_pkg::word_t o_redirect_target,
    output logic            o_redirect_is_trap,
    output logic            o_fetch_flush
);
    import trap_pkg::*;

    logic  w_timer_int;
    logic  w_ext_int;
    logic  w_trap_pending;
    word_t w_trap_code;
    word_t w_trap_base;
    word_t w_trap_target;

    logic  r_trap_redirect_valid;
    word_t r_trap_target;

    // Interrupts only count while the global enable is set
    always_comb begin
        w_timer_int    = i_mstatus_mie & i_timer_pending;
        w_ext_int      = i_mstatus_mie & i_ext_pending;
        w_trap_pending = w_timer_int | w_ext_int;
    end

    // External has priority over timer. With nothing pending the code is
    // unused, so the timer code is as good as any
    always_comb begin
        if (w_ext_int) begin
            w_trap_code = INT_CODE_EXTERNAL;
        end else begin
            w_trap_code = INT_CODE_TIMER;
        end
        o_trap_cause = {1'b1, w_trap_code[30:0]};
    end

    // Vectored mode jumps to base + 4 * code, everything else to the base
    always_comb begin
        w_trap_base = {i_mtvec[31:2], 2'b00};
        if (i_mtvec[1:0] == MTVEC_MODE_VECTORED) begin
            w_trap_target = w_trap_base + (w_trap_code << 2);
        end else begin
            w_trap_target = w_trap_base;
        end
    end

    // Dispatch waits until no instruction is left in flight
    always_comb begin
        o_trap_dispatch = w_trap_pending & i_pipeline_empty;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_trap_redirect_valid <= 1'b0;
        end else begin
            r_trap_redirect_valid <= o_trap_dispatch;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_trap_dispatch) begin
            r_trap_target <= w_trap_target;
        end
    end

    // A branch redirect goes straight through, the trap redirect only
    // fills in when no branch is redirecting
    always_comb begin
        if (i_branch_redirect_valid) begin
            o_redirect_valid   = 1'b1;
            o_redirect_target  = i_branch_target;
            o_redirect_is_trap = 1'b0;
        end else begin
            o_redirect_valid   = r_trap_redirect_valid;
            o_redirect_target  = r_trap_target;
            o_redirect_is_trap = r_trap_redirect_valid;
        end
    end

    // Fetch stays flushed while a trap is pending so the pipeline drains
    always_comb begin
        o_fetch_flush = o_redirect_valid | w_trap_pending;
    end

endmodule

`default_nettype wire

/* hdl/machine_trap_unit.sv */
`default_nettype none

module machine_trap_unit #(
    parameter trap_pkg::word_t MTVEC_RESET_BASE = '0
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_int_timer,
    input  logic                  i_int_ext,
    input  logic                  i_csr_w_en,
    input  trap_pkg::csr_addr_t   i_csr_addr,
    input  trap_pkg::csr_w_type_t i_csr_w_type,
    input  trap_pkg::word_t       i_csr_operand,
    input  logic                  i_restore_int_en,
    input  logic                  i_pipeline_empty,
    input  trap_pkg::word_t       i_fetch_pc,
    input  logic                  i_branch_redirect_valid,
    input  trap_pkg::word_t       i_branch_target,
    output trap_pkg::word_t       o_csr_r_data,
    output trap_pkg::word_t       o_mepc,
    output logic                  o_redirect_valid,
    output trap_pkg::word_t       o_redirect_target,
    output logic                  o_redirect_is_trap,
    output logic                  o_fetch_flush
);
    import trap_pkg::*;

    // CSR state towards the controller
    logic  w_mstatus_mie;
    logic  w_timer_pending;
    logic  w_ext_pending;
    word_t w_mtvec;

    // Trap entry back towards the CSRs
    logic  w_trap_dispatch;
    word_t w_trap_cause;

    csr_file #(
        .MTVEC_RESET_BASE(MTVEC_RESET_BASE)
    ) csr_file_inst (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_int_timer     (i_int_timer),
        .i_int_ext       (i_int_ext),
        .i_csr_w_en      (i_csr_w_en),
        .i_csr_addr      (i_csr_addr),
        .i_csr_w_type    (i_csr_w_type),
        .i_csr_operand   (i_csr_operand),
        .i_restore_int_en(i_restore_int_en),
        .i_trap_dispatch (w_trap_dispatch),
        .i_trap_cause    (w_trap_cause),
        .i_fetch_pc      (i_fetch_pc),
        .o_csr_r_data    (o_csr_r_data),
        .o_mepc          (o_mepc),
        .o_mtvec         (w_mtvec),
        .o_mstatus_mie   (w_mstatus_mie),
        .o_timer_pending (w_timer_pending),
        .o_ext_pending   (w_ext_pending)
    );

    trap_controller trap_controller_inst (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_mstatus_mie          (w_mstatus_mie),
        .i_timer_pending        (w_timer_pending),
        .i_ext_pending          (w_ext_pending),
        .i_mtvec                (w_mtvec),
        .i_pipeline_empty       (i_pipeline_empty),
        .i_branch_redirect_valid(i_branch_redirect_valid),
        .i_branch_target        (i_branch_target),
        .o_trap_dispatch        (w_trap_dispatch),
        .o_trap_cause           (w_trap_cause),
        .o_redirect_valid       (o_redirect_valid),
        .o_redirect_target      (o_redirect_target),
        .o_redirect_is_trap     (o_redirect_is_trap),
        .o_fetch_flush          (o_fetch_flush)
    );

endmodule

`default_nettype wire

/* tb/trap_unit_checker.sv */
`default_nettype none

module trap_unit_checker (
    input logic i_clk,
    input logic i_rst,
    input logic i_csr_w_en,
    input logic i_restore_int_en,
    input logic i_branch_redirect_valid,
    input logic i_redirect_valid,
    input logic i_redirect_is_trap
);
    timeunit 1ns;
    timeprecision 1ns;

    // A CSR instruction and a return from trap never issue together
    no_write_with_restore: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_csr_w_en && i_restore_int_en)
    ) else $error("CSR write and restore strobed in the same cycle");

    trap_flag_needs_valid: assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_redirect_is_trap |-> i_redirect_valid
    ) else $error("Trap flag raised without a valid redirect");

    // The branch redirect always owns the redirect port
    branch_over_trap: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_branch_redirect_valid && i_redirect_is_trap)
    ) else $error("Trap redirect shown while a branch redirect is active");

endmodule

`default_nettype wire

/* tb/trap_unit_tb.sv */
`default_nettype none

module trap_unit_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import trap_pkg::*;

    localparam int RESET_CYCLES = 4;
    // The six tests take about 80 cycles and the limit leaves ample margin
    localparam int TIMEOUT_CYCLES = 400;
    localparam csr_addr_t UNKNOWN_ADDR = 12'h7C0;

    logic      clk;
    logic      rst;
    logic      int_timer;
    logic      int_ext;
    logic      csr_w_en;
    csr_addr_t csr_addr;
    csr_w_type_t csr_w_type;
    word_t     csr_operand;
    logic      restore_int_en;
    logic      pipeline_empty;
    word_t     fetch_pc;
    logic      branch_valid;
    word_t     branch_target;
    word_t     csr_r_data;
    word_t     mepc;
    logic      redirect_valid;
    word_t     redirect_target;
    logic      redirect_is_trap;
    logic      fetch_flush;

    // Vector table base set up by the vectored test and still in mtvec afterwards
    word_t     vectored_base;

    integer seed;
    int     error_count;
    int     check_count;
    int     cycle_count = 0;

    machine_trap_unit #(
        .MTVEC_RESET_BASE(32'h0)
    ) machine_trap_unit_inst (
        .i_clk                  (clk),
        .i_rst                  (rst),
        .i_int_timer            (int_timer),
        .i_int_ext              (int_ext),
        .i_csr_w_en             (csr_w_en),
        .i_csr_addr             (csr_addr),
        .i_csr_w_type           (csr_w_type),
        .i_csr_operand          (csr_operand),
        .i_restore_int_en       (restore_int_en),
        .i_pipeline_empty       (pipeline_empty),
        .i_fetch_pc             (fetch_pc),
        .i_branch_redirect_valid(branch_valid),
        .i_branch_target        (branch_target),
        .o_csr_r_data           (csr_r_data),
        .o_mepc                 (mepc),
        .o_redirect_valid       (redirect_valid),
        .o_redirect_target      (redirect_target),
        .o_redirect_is_trap     (redirect_is_trap),
        .o_fetch_flush          (fetch_flush)
    );

    bind machine_trap_unit trap_unit_checker trap_unit_checker_inst (
        .i_clk                  (i_clk),
        .i_rst                  (i_rst),
        .i_csr_w_en             (i_csr_w_en),
        .i_restore_int_en       (i_restore_int_en),
        .i_branch_redirect_valid(i_branch_redirect_valid),
        .i_redirect_valid       (o_redirect_valid),
        .i_redirect_is_trap     (o_redirect_is_trap)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input word_t got, input word_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, expected);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input csr_w_type_t kind, input word_t op);
        @(posedge clk);
        csr_w_en    <= 1'b1;
        csr_addr    <= addr;
        csr_w_type  <= kind;
        csr_operand <= op;
        @(posedge clk);
        csr_w_en <= 1'b0;
    endtask

    // Read data appears one edge after the address is presented
    task automatic csr_read(input csr_addr_t addr, output word_t data);
        @(posedge clk);
        csr_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        data = csr_r_data;
    endtask

    // mip samples the lines at the next edge and dispatch follows one edge later
    task automatic take_interrupt(input logic timer, input logic ext, input word_t target);
        @(posedge clk);
        int_timer <= timer;
        int_ext   <= ext;
        @(posedge clk);
        @(negedge clk);
        check_bit("redirect before dispatch", redirect_valid, 1'b0);
        check_bit("flush with trap pending", fetch_flush, 1'b1);
        @(posedge clk);
        @(negedge clk);
        check_bit("trap redirect valid", redirect_valid, 1'b1);
        check_bit("trap redirect flag", redirect_is_trap, 1'b1);
        check_word("trap target", redirect_target, target);
        @(posedge clk);
        int_timer <= 1'b0;
        int_ext   <= 1'b0;
        @(negedge clk);
        check_bit("redirect after one cycle", redirect_valid, 1'b0);
    endtask

    task automatic reset_and_csr_access();
        word_t value;
        word_t op;
        word_t expected;
        @(negedge clk);
        check_bit("redirect valid after reset", redirect_valid, 1'b0);
        check_bit("redirect flag after reset", redirect_is_trap, 1'b0);
        check_bit("flush after reset", fetch_flush, 1'b0);
        csr_read(CSR_ADDR_MTVEC, value);
        check_word("mtvec after reset", value, 32'h0);
        op = $random(seed);
        expected = op;
        csr_write(CSR_ADDR_MSCRATCH, CSR_W_COPY, op);
        csr_read(CSR_ADDR_MSCRATCH, value);
        check_word("mscratch after copy", value, expected);
        op = $random(seed);
        expected = expected | op;
        csr_write(CSR_ADDR_MSCRATCH, CSR_W_SET, op);
        csr_read(CSR_ADDR_MSCRATCH, value);
        check_word("mscratch after set", value, expected);
        op = $random(seed);
        expected = expected & ~op;
        csr_write(CSR_ADDR_MSCRATCH, CSR_W_CLEAR, op);
        csr_read(CSR_ADDR_MSCRATCH, value);
        check_word("mscratch after clear", value, expected);
        // Both lines are low, so mip keeps reading zero. The address stays on
        // mip, and the read port shows the register right after the write edge,
        // before the lines are sampled into it again
        csr_write(CSR_ADDR_MIP, CSR_W_COPY, 32'hFFFF_FFFF);
        @(posedge clk);
        @(negedge clk);
        check_word("mip after write", csr_r_data, 32'h0);
        op = $random(seed);
        csr_write(UNKNOWN_ADDR, CSR_W_COPY, op);
        csr_read(UNKNOWN_ADDR, value);
        check_word("unknown CSR", value, 32'h0);
    endtask

    task automatic return_from_trap();
        word_t value;
        word_t expected;
        value = '0;
        value[MSTATUS_MPIE_BIT] = 1'b1;
        csr_write(CSR_ADDR_MSTATUS, CSR_W_COPY, value);
        @(posedge clk);
        restore_int_en <= 1'b1;
        @(posedge clk);
        restore_int_en <= 1'b0;
        expected = '0;
        expected[MSTATUS_MIE_BIT]  = 1'b1;
        expected[MSTATUS_MPIE_BIT] = 1'b1;
        csr_read(CSR_ADDR_MSTATUS, value);
        check_word("mstatus after restore", value, expected);
    endtask

    task automatic vectored_timer_interrupt();
        word_t base;
        word_t pc;
        word_t value;
        word_t expected;
        base = $random(seed) & 32'hFFFF_FFFC;
        pc   = $random(seed) & 32'hFFFF_FFFC;
        vectored_base = base;
        @(posedge clk);
        fetch_pc <= pc;
        csr_write(CSR_ADDR_MTVEC, CSR_W_COPY, base | {30'b0, MTVEC_MODE_VECTORED});
        csr_read(CSR_ADDR_MTVEC, value);
        check_word("mtvec vectored", value, base | {30'b0, MTVEC_MODE_VECTORED});
        value = '0;
        value[INT_TIMER_BIT] = 1'b1;
        csr_write(CSR_ADDR_MIE, CSR_W_COPY, value);
        value = '0;
        value[MSTATUS_MIE_BIT] = 1'b1;
        csr_write(CSR_ADDR_MSTATUS, CSR_W_COPY, value);
        take_interrupt(1'b1, 1'b0, base + 4 * INT_CODE_TIMER);
        check_word("mepc after trap", mepc, pc);
        csr_read(CSR_ADDR_MCAUSE, value);
        check_word("mcause after timer trap", value, 32'h8000_0000 | INT_CODE_TIMER);
        expected = '0;
        expected[MSTATUS_MPIE_BIT] = 1'b1;
        csr_read(CSR_ADDR_MSTATUS, value);
        check_word("mstatus after trap", value, expected);
    endtask

    task automatic dispatch_held_while_busy();
        word_t value;
        @(posedge clk);
        pipeline_empty <= 1'b0;
        value = '0;
        value[MSTATUS_MIE_BIT] = 1'b1;
        csr_write(CSR_ADDR_MSTATUS, CSR_W_COPY, value);
        @(posedge clk);
        int_timer <= 1'b1;
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_bit("flush while busy", fetch_flush, 1'b1);
            check_bit("redirect while busy", redirect_valid, 1'b0);
        end
        @(posedge clk);
        pipeline_empty <= 1'b1;
        @(negedge clk);
        check_bit("redirect on empty edge", redirect_valid, 1'b0);
        @(negedge clk);
        check_bit("redirect after empty", redirect_valid, 1'b1);
        check_bit("redirect flag after empty", redirect_is_trap, 1'b1);
        check_word("target after empty", redirect_target,
                   vectored_base + 4 * INT_CODE_TIMER);
        @(posedge clk);
        int_timer <= 1'b0;
        @(negedge clk);
        check_bit("redirect after busy trap", redirect_valid, 1'b0);
    endtask

    task automatic direct_mode_priority();
        word_t base;
        word_t value;
        base = $random(seed) & 32'hFFFF_FFFC;
        csr_write(CSR_ADDR_MTVEC, CSR_W_COPY, base | {30'b0, MTVEC_MODE_DIRECT});
        value = '0;
        value[INT_TIMER_BIT]    = 1'b1;
        value[INT_EXTERNAL_BIT] = 1'b1;
        csr_write(CSR_ADDR_MIE, CSR_W_COPY, value);
        value = '0;
        value[MSTATUS_MIE_BIT] = 1'b1;
        csr_write(CSR_ADDR_MSTATUS, CSR_W_COPY, value);
        take_interrupt(1'b1, 1'b1, base);
        csr_read(CSR_ADDR_MCAUSE, value);
        check_word("mcause with both pending", value, 32'h8000_0000 | INT_CODE_EXTERNAL);
    endtask

    task automatic branch_redirect_passthrough();
        word_t target;
        target = $random(seed);
        @(posedge clk);
        branch_valid  <= 1'b1;
        branch_target <= target;
        @(negedge clk);
        check_bit("branch redirect valid", redirect_valid, 1'b1);
        check_bit("branch redirect flag", redirect_is_trap, 1'b0);
        check_word("branch target", redirect_target, target);
        check_bit("flush on branch", fetch_flush, 1'b1);
        @(posedge clk);
        branch_valid <= 1'b0;
        @(negedge clk);
        check_bit("redirect after branch", redirect_valid, 1'b0);
        check_bit("flush after branch", fetch_flush, 1'b0);
    endtask

    initial begin
        seed           = 89163;
        error_count    = 0;
        check_count    = 0;
        rst            = 1'b1;
        int_timer      = 1'b0;
        int_ext        = 1'b0;
        csr_w_en       = 1'b0;
        csr_addr       = '0;
        csr_w_type     = CSR_W_COPY;
        csr_operand    = '0;
        restore_int_en = 1'b0;
        pipeline_empty = 1'b1;
        fetch_pc       = '0;
        branch_valid   = 1'b0;
        branch_target  = '0;
        vectored_base  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        reset_and_csr_access();
        return_from_trap();
        vectored_timer_interrupt();
        dispatch_held_while_busy();
        direct_mode_priority();
        branch_redirect_passthrough();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/trap_pkg.sv
hdl/csr_file.sv
hdl/trap_controller.sv
hdl/machine_trap_unit.sv
tb/trap_unit_checker.sv
tb/trap_unit_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module trap_unit_tb \
    -f filelist.f \
    -o trap_unit_sim

output=$(./obj_dir/trap_unit_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
